// ==== flist.f ====
logic/memory_game_pkg.sv
logic/play_input.sv
logic/round_counters.sv
logic/play_checker.sv
logic/game_fsm.sv
logic/memory_game.sv
bench/memory_game_tb.sv

// ==== Bender.yml ====
package:
  name: memory_game

dependencies: {}

sources:
  # Package first, then leaf modules, then the top level
  - logic/memory_game_pkg.sv
  - logic/play_input.sv
  - logic/round_counters.sv
  - logic/play_checker.sv
  - logic/game_fsm.sv
  - logic/memory_game.sv

  # Testbench, only for simulation
  - target: test
    files:
      - bench/memory_game_tb.sv

// ==== bench/memory_game_tb.sv ====
`timescale 1ns/10ps

module memory_game_tb
    import memory_game_pkg::*;
();

    // Covers 136 presses of about 12 cycles, two timeouts and margin
    localparam int WATCHDOG_NS = 250_000;

    logic    clock;
    logic    reset;
    logic    start;
    button_t buttons;
    button_t leds;
    logic    done;
    logic    win;
    logic    lose;

    int error_count = 0;
    int check_count = 0;

    memory_game DUT (
        .clock   (clock),
        .reset   (reset),
        .start   (start),
        .buttons (buttons),
        .leds    (leds),
        .done    (done),
        .win     (win),
        .lose    (lose)
    );

    // 8 ns period
    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    // Inputs change and outputs are read 1 ns past the edge
    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic expect_equal(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        check_count++;
        assert (actual === expected) else begin
            $display("Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    // One cycle start and time for the FSM to reach wait_play
    task automatic pulse_start();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        repeat (3) next_cycle();
    endtask

    // Hold 4 cycles, release 4 cycles
    task automatic press(input button_t value);
        buttons = value;
        repeat (4) next_cycle();
        buttons = '0;
        repeat (4) next_cycle();
    endtask

    // Round k repeats entries 0 to k
    task automatic play_round(input int k);
        for (int i = 0; i <= k; i++) begin
            press(SEQUENCE_TABLE[i]);
        end
    endtask

    task automatic wait_done(input int max_cycles);
        int waited;
        waited = 0;
        while (!done && waited < max_cycles) begin
            next_cycle();
            waited++;
        end
        check_count++;
        assert (done) else begin
            $display("Error at %0t: done did not rise within %0d cycles", $time, max_cycles);
            error_count++;
        end
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------

    task automatic check_after_reset();
        expect_equal("done", done, 1'b0);
        expect_equal("win", win, 1'b0);
        expect_equal("lose", lose, 1'b0);
        expect_equal("leds", leds, '0);
    endtask

    // All 16 rounds right
    task automatic run_full_game();
        pulse_start();
        for (int k = 0; k < SEQUENCE_DEPTH; k++) begin
            play_round(k);
        end
        wait_done(20);
        expect_equal("win", win, 1'b1);
        expect_equal("lose", lose, 1'b0);
        expect_equal("leds", leds, SEQUENCE_TABLE[SEQUENCE_DEPTH-1]);
    endtask

    // Round 0 right and no more presses
    task automatic time_out_waiting();
        bit stayed_low;
        pulse_start();
        play_round(0);
        stayed_low = 1'b1;
        // Four release cycles already passed inside press
        for (int i = 0; i < TIMEOUT_CYCLES - 12; i++) begin
            if (done) begin
                stayed_low = 1'b0;
            end
            next_cycle();
        end
        check_count++;
        assert (stayed_low) else begin
            $display("Error at %0t: done rose before the wait limit ran out", $time);
            error_count++;
        end
        wait_done(24);
        expect_equal("win", win, 1'b0);
        expect_equal("lose", lose, 1'b0);
    endtask

    // Last entry of a random round played wrong
    task automatic lose_on_wrong_play();
        int      bad_round;
        button_t wrong;
        bad_round = $urandom % SEQUENCE_DEPTH;
        // Nonzero so it counts as a press
        do begin
            wrong = button_t'($urandom % 15 + 1);
        end while (wrong == SEQUENCE_TABLE[bad_round]);
        pulse_start();
        for (int k = 0; k < bad_round; k++) begin
            play_round(k);
        end
        for (int i = 0; i < bad_round; i++) begin
            press(SEQUENCE_TABLE[i]);
        end
        press(wrong);
        wait_done(20);
        expect_equal("lose", lose, 1'b1);
        expect_equal("win", win, 1'b0);
        expect_equal("leds", leds, wrong);
    endtask

    // From end_lose back to a running game
    task automatic restart_after_loss();
        pulse_start();
        expect_equal("leds", leds, '0);
        expect_equal("done", done, 1'b0);
        expect_equal("win", win, 1'b0);
        expect_equal("lose", lose, 1'b0);
        play_round(0);
        repeat (8) begin
            expect_equal("done", done, 1'b0);
            next_cycle();
        end
        expect_equal("leds", leds, SEQUENCE_TABLE[0]);
    endtask

    // ----------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------

    initial begin
        reset   = 1'b1;
        start   = 1'b0;
        buttons = '0;
        void'($urandom(32'h3c9f14dc));
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        next_cycle();
        check_after_reset();
        run_full_game();
        time_out_waiting();
        lose_on_wrong_play();
        restart_after_loss();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t, the tests never finished", $time);
        $display("Checks: %0d, errors: %0d", check_count, error_count + 1);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== logic/memory_game.sv ====
`timescale 1ns/10ps

module memory_game
    import memory_game_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  logic    start,
    input  button_t buttons,
    output button_t leds,
    output logic    done,
    output logic    win,
    output logic    lose
);

    // ----------------------------------------
    // Internal wiring
    // ----------------------------------------

    logic          play_strobe;
    logic          match;
    address_t      position;
    fsm_ctrl_t     ctrl;
    round_status_t status;

    // Press detection and capture, the captured play drives the leds
    play_input u_play_input (
        .clock       (clock),
        .reset       (reset),
        .buttons     (buttons),
        .ctrl        (ctrl),
        .play_strobe (play_strobe),
        .play        (leds)
    );

    // Position, round and wait timer
    round_counters u_round_counters (
        .clock    (clock),
        .reset    (reset),
        .ctrl     (ctrl),
        .position (position),
        .status   (status)
    );

    // Expected entry lookup and compare
    play_checker u_play_checker (
        .clock    (clock),
        .reset    (reset),
        .position (position),
        .play     (leds),
        .match    (match)
    );

    // Game sequencing
    game_fsm u_game_fsm (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .play_strobe (play_strobe),
        .match       (match),
        .status      (status),
        .ctrl        (ctrl),
        .done        (done),
        .win         (win),
        .lose        (lose)
    );

endmodule

// ==== logic/game_fsm.sv ====
`timescale 1ns/10ps

module game_fsm
    import memory_game_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          start,
    input  logic          play_strobe,
    input  logic          match,
    input  round_status_t status,
    output fsm_ctrl_t     ctrl,
    output logic          done,
    output logic          win,
    output logic          lose
);

    game_state_e state;
    game_state_e next_state;

    // ----------------------------------------
    // State register and result flags
    // ----------------------------------------

    // Flags decoded from next_state so they line up with the state
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
            done  <= 1'b0;
            win   <= 1'b0;
            lose  <= 1'b0;
        end else begin
            state <= next_state;
            done  <= (next_state == end_timeout) || (next_state == end_win) ||
                     (next_state == end_lose);
            win   <= (next_state == end_win);
            lose  <= (next_state == end_lose);
        end
    end

    // ----------------------------------------
    // Next state
    // ----------------------------------------

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (start) begin
                    next_state = prepare;
                end
            end
            prepare:     next_state = start_round;
            start_round: next_state = wait_play;
            wait_play: begin
                // A press wins over the timeout in the same cycle
                if (play_strobe) begin
                    next_state = capture_play;
                end else if (status.timed_out) begin
                    next_state = end_timeout;
                end
            end
            capture_play: next_state = judge_play;
            judge_play: begin
                if (match && status.position_below_round) begin
                    next_state = next_position;
                end else if (match && status.position_at_round) begin
                    next_state = check_last_round;
                end else begin
                    next_state = end_lose;
                end
            end
            next_position: next_state = wait_play;
            check_last_round: begin
                if (status.last_round) begin
                    next_state = end_win;
                end else begin
                    next_state = next_round;
                end
            end
            next_round: next_state = start_round;
            // Game over, wait for a restart
            end_timeout, end_win, end_lose: begin
                if (start) begin
                    next_state = prepare;
                end
            end
            default: next_state = idle;
        endcase
    end

    // ----------------------------------------
    // Control strobes
    // ----------------------------------------

    // Moore decode of the current state
    always_comb begin
        ctrl = '0;
        case (state)
            idle: begin
                ctrl.clear_position = 1'b1;
                ctrl.clear_round    = 1'b1;
                ctrl.clear_play     = 1'b1;
            end
            prepare: begin
                // Position too, a lost game can leave it mid round
                ctrl.clear_position = 1'b1;
                ctrl.clear_round    = 1'b1;
                ctrl.clear_play     = 1'b1;
            end
            wait_play:     ctrl.timing        = 1'b1;
            capture_play:  ctrl.capture       = 1'b1;
            next_position: ctrl.step_position = 1'b1;
            next_round: begin
                ctrl.clear_position = 1'b1;
                ctrl.step_round     = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== logic/play_checker.sv ====
`timescale 1ns/10ps

module play_checker
    import memory_game_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  address_t position,
    input  button_t  play,
    output logic     match
);

    // ----------------------------------------
    // Sequence ROM
    // ----------------------------------------

    // Table entry at the current position, one edge late
    button_t expected;

    // Synchronous read, position settles well before judging
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            expected <= '0;
        end else begin
            expected <= SEQUENCE_TABLE[position];
        end
    end

    // ----------------------------------------
    // Judgement
    // ----------------------------------------

    // Only read by the FSM in judge_play
    // Exact match needed, two buttons at once never match a one-hot entry
    assign match = (play == expected);

endmodule

// ==== logic/round_counters.sv ====
`timescale 1ns/10ps

module round_counters
    import memory_game_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  fsm_ctrl_t     ctrl,
    output address_t      position,
    output round_status_t status
);

    // Round being played
    address_t round;
    // Cycles spent waiting for a play
    logic [TIMER_WIDTH-1:0] timer;

    // ----------------------------------------
    // Position counter
    // ----------------------------------------

    // Entry being played within the round
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            position <= '0;
        end else if (ctrl.clear_position) begin
            position <= '0;
        end else if (ctrl.step_position) begin
            // Wraps at the end of the table through the counter width
            position <= position + 1'b1;
        end
    end

    // ----------------------------------------
    // Round counter
    // ----------------------------------------

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            round <= '0;
        end else if (ctrl.clear_round) begin
            round <= '0;
        end else if (ctrl.step_round) begin
            // Same wrap as the position counter
            round <= round + 1'b1;
        end
    end

    // ----------------------------------------
    // Wait timer
    // ----------------------------------------

    // Runs only while waiting and clears otherwise
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            timer <= '0;
        end else if (!ctrl.timing) begin
            timer <= '0;
        end else begin
            timer <= timer + 1'b1;
        end
    end

    // Status flags straight from the registers
    always_comb begin
        status.position_below_round = (position < round);
        status.position_at_round    = (position == round);
        status.last_round           = (round == ADDRESS_WIDTH'(SEQUENCE_DEPTH - 1));
        status.timed_out            = (timer == TIMER_WIDTH'(TIMEOUT_CYCLES - 1));
    end

endmodule

// ==== logic/play_input.sv ====
`timescale 1ns/10ps

module play_input
    import memory_game_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  button_t   buttons,
    input  fsm_ctrl_t ctrl,
    output logic      play_strobe,
    output button_t   play
);

    // ----------------------------------------
    // Press detection
    // ----------------------------------------

    // Any button down
    logic any_button;
    // Two samples of any_button
    logic sample_now;
    logic sample_prev;

    assign any_button = |buttons;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            sample_now  <= 1'b0;
            sample_prev <= 1'b0;
        end else begin
            sample_now  <= any_button;
            sample_prev <= sample_now;
        end
    end

    // One cycle pulse on zero to nonzero, releases give nothing
    assign play_strobe = sample_now & ~sample_prev;

    // ----------------------------------------
    // Play register
    // ----------------------------------------

    // Holds the last captured play, also shown on the leds
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            play <= '0;
        end else if (ctrl.clear_play) begin
            play <= '0;
        end else if (ctrl.capture) begin
            play <= buttons;
        end
    end

endmodule

// ==== logic/memory_game_pkg.sv ====
package memory_game_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------

    // One bit per button
    localparam int BUTTON_WIDTH = 4;
    typedef logic [BUTTON_WIDTH-1:0] button_t;

    // Sequence position and round index
    localparam int ADDRESS_WIDTH = 4;
    typedef logic [ADDRESS_WIDTH-1:0] address_t;

    // Entries in the sequence and number of rounds
    localparam int SEQUENCE_DEPTH = 16;

    // ----------------------------------------
    // Sequence contents and wait limit
    // ----------------------------------------

    // One-hot expected play per position
    localparam button_t SEQUENCE_TABLE [SEQUENCE_DEPTH] = '{
        4'b0001, 4'b0010, 4'b0100, 4'b1000,
        4'b0100, 4'b0010, 4'b0001, 4'b0001,
        4'b0010, 4'b0010, 4'b0100, 4'b0100,
        4'b1000, 4'b1000, 4'b0001, 4'b0100
    };

    // Cycles allowed between plays
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int TIMER_WIDTH = 12;

    // ----------------------------------------
    // Control types
    // ----------------------------------------

    // End states at the top of the code space
    typedef enum logic [3:0] {
        idle             = 4'h0,
        prepare          = 4'h1,
        start_round      = 4'h2,
        wait_play        = 4'h3,
        capture_play     = 4'h4,
        judge_play       = 4'h5,
        next_position    = 4'h6,
        check_last_round = 4'h7,
        next_round       = 4'h8,
        end_timeout      = 4'hd,
        end_win          = 4'he,
        end_lose         = 4'hf
    } game_state_e;

    // Strobes from the FSM to the datapath
    typedef struct packed {
        logic clear_position;
        logic step_position;
        logic clear_round;
        logic step_round;
        logic clear_play;
        logic capture;
        logic timing;
    } fsm_ctrl_t;

    // Flags from the counters back to the FSM
    typedef struct packed {
        logic position_below_round;
        logic position_at_round;
        logic last_round;
        logic timed_out;
    } round_status_t;

endpackage
